// File: rtl/pattgen_pkg.sv
package pattgen_pkg;

    localparam int NUM_CH          = 4;
    localparam int LINE_BEATS      = 16;
    localparam int LINES_PER_FRAME = 4;
    localparam int CREDITS         = 4;
    localparam int FIFO_AW         = $clog2(CREDITS);

    // pixel layout is frame[15:10], channel[9:8], line[7:4], beat[3:0]
    typedef logic [15:0] pixel_t;
    typedef logic [1:0]  ch_t;
    typedef logic [3:0]  ch_mask_t;
    typedef logic [5:0]  frame_t;
    typedef logic [3:0]  line_t;
    typedef logic [3:0]  beat_t;
    typedef logic [2:0]  credit_t;

    typedef logic [FIFO_AW-1:0] addr_t;
    typedef logic [FIFO_AW:0]   ptr_t;    // one extra bit tells full from empty

    typedef enum logic {
        GEN_IDLE,
        GEN_ACTIVE
    } gen_state_t;

endpackage

// File: rtl/frame_scheduler.sv
module frame_scheduler (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  pattgen_pkg::ch_mask_t ch_enable,
    input  pattgen_pkg::ch_mask_t done,
    output pattgen_pkg::ch_mask_t start,
    output pattgen_pkg::frame_t   frame
);

    pattgen_pkg::ch_mask_t pending;     // channels still working on this frame
    pattgen_pkg::ch_mask_t pending_next;
    logic                  idle;
    logic                  frame_end;
    logic                  launch;

    assign pending_next = pending & ~done;
    assign idle         = pending == '0;
    assign frame_end    = !idle && pending_next == '0;

    // the next frame may start right on the cycle the last channel finishes
    assign launch = enable && ch_enable != '0 && (idle || frame_end);

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            start   <= '0;
            frame   <= '0;
        end else begin
            start   <= '0;
            pending <= pending_next;

            if (frame_end) begin
                frame <= frame + 1'b1;
            end

            // mask is sampled only here, so a change waits for the frame boundary
            if (launch) begin
                start   <= ch_enable;
                pending <= ch_enable;
            end
        end
    end

endmodule

// File: rtl/pattern_gen.sv
module pattern_gen (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  pattgen_pkg::frame_t frame,
    input  pattgen_pkg::ch_t    ch,
    input  logic                credit_ret,
    output logic                beat_valid,
    output pattgen_pkg::pixel_t beat_data,
    output logic                beat_last,
    output logic                beat_user,
    output logic                done
);

    pattgen_pkg::gen_state_t state;
    pattgen_pkg::beat_t      beat;
    pattgen_pkg::line_t      line;
    pattgen_pkg::credit_t    credits;    // free slots in this channel's merger buffer
    logic                    last_line;

    // a beat goes out only while a slot downstream is guaranteed
    assign beat_valid = state == pattgen_pkg::GEN_ACTIVE && credits != '0;

    assign beat_last = beat == pattgen_pkg::beat_t'(pattgen_pkg::LINE_BEATS - 1);
    assign last_line = line == pattgen_pkg::line_t'(pattgen_pkg::LINES_PER_FRAME - 1);
    assign beat_user = line == '0 && beat == '0;
    assign beat_data = {frame, ch, line, beat};
    assign done      = beat_valid && beat_last && last_line;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= pattgen_pkg::GEN_IDLE;
            beat    <= '0;
            line    <= '0;
            credits <= pattgen_pkg::credit_t'(pattgen_pkg::CREDITS);
        end else begin
            // a returned credit shows up one cycle after the merger pops
            credits <= credits - pattgen_pkg::credit_t'(beat_valid)
                               + pattgen_pkg::credit_t'(credit_ret);

            if (start) begin
                state <= pattgen_pkg::GEN_ACTIVE;
                beat  <= '0;
                line  <= '0;
            end else if (beat_valid) begin
                if (beat_last) begin
                    beat <= '0;
                    if (last_line) begin
                        line  <= '0;
                        state <= pattgen_pkg::GEN_IDLE;    // frame complete, wait for start
                    end else begin
                        line <= line + 1'b1;
                    end
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/stream_merger.sv
module stream_merger (
    input  logic                  clk,
    input  logic                  rst,
    input  pattgen_pkg::ch_mask_t beat_valid,
    input  pattgen_pkg::pixel_t   beat_data [pattgen_pkg::NUM_CH],
    input  pattgen_pkg::ch_mask_t beat_last,
    input  pattgen_pkg::ch_mask_t beat_user,
    output pattgen_pkg::ch_mask_t credit_ret,
    input  logic                  out_ready,
    output logic                  out_valid,
    output pattgen_pkg::pixel_t   out_data,
    output pattgen_pkg::ch_t      out_dest,
    output logic                  out_last,
    output logic                  out_user
);

    pattgen_pkg::pixel_t   fifo_data [pattgen_pkg::NUM_CH][pattgen_pkg::CREDITS];
    logic                  fifo_last [pattgen_pkg::NUM_CH][pattgen_pkg::CREDITS];
    logic                  fifo_user [pattgen_pkg::NUM_CH][pattgen_pkg::CREDITS];
    pattgen_pkg::ptr_t     wr_ptr [pattgen_pkg::NUM_CH];
    pattgen_pkg::ptr_t     rd_ptr [pattgen_pkg::NUM_CH];
    pattgen_pkg::ch_mask_t empty;

    pattgen_pkg::ch_t      grant;      // channel of the most recent pop
    logic                  in_line;    // grant is locked until its line closes
    pattgen_pkg::ch_t      rr_pick;
    logic                  rr_found;
    pattgen_pkg::ch_t      sel;
    pattgen_pkg::addr_t    head;
    logic                  load;
    logic                  pop;

    always_comb begin
        for (int c = 0; c < pattgen_pkg::NUM_CH; c++) begin
            empty[c] = wr_ptr[c] == rd_ptr[c];
        end
    end

    // search starts one past the last grant, so every channel gets its turn
    always_comb begin
        rr_pick  = grant;
        rr_found = 1'b0;
        for (int i = 1; i <= pattgen_pkg::NUM_CH; i++) begin
            if (!rr_found && !empty[pattgen_pkg::ch_t'(grant + i)]) begin
                rr_pick  = pattgen_pkg::ch_t'(grant + i);
                rr_found = 1'b1;
            end
        end
    end

    assign sel  = in_line ? grant : rr_pick;
    assign head = rd_ptr[sel][pattgen_pkg::FIFO_AW-1:0];
    assign load = !out_valid || out_ready;    // output register is free this cycle
    assign pop  = load && !empty[sel];

    assign credit_ret = pop ? pattgen_pkg::ch_mask_t'(1) << sel : '0;

    // credits keep every writer within the buffer depth
    always_ff @(posedge clk) begin
        for (int c = 0; c < pattgen_pkg::NUM_CH; c++) begin
            if (beat_valid[c]) begin
                fifo_data[c][wr_ptr[c][pattgen_pkg::FIFO_AW-1:0]] <= beat_data[c];
                fifo_last[c][wr_ptr[c][pattgen_pkg::FIFO_AW-1:0]] <= beat_last[c];
                fifo_user[c][wr_ptr[c][pattgen_pkg::FIFO_AW-1:0]] <= beat_user[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < pattgen_pkg::NUM_CH; c++) begin
                wr_ptr[c] <= '0;
                rd_ptr[c] <= '0;
            end
            grant     <= pattgen_pkg::ch_t'(pattgen_pkg::NUM_CH - 1);    // channel 0 goes first
            in_line   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            for (int c = 0; c < pattgen_pkg::NUM_CH; c++) begin
                if (beat_valid[c]) begin
                    wr_ptr[c] <= wr_ptr[c] + 1'b1;
                end
            end

            out_valid <= out_valid && !out_ready;

            if (pop) begin
                rd_ptr[sel] <= rd_ptr[sel] + 1'b1;
                grant       <= sel;
                in_line     <= !fifo_last[sel][head];
                out_valid   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_data <= fifo_data[sel][head];
            out_dest <= sel;
            out_last <= fifo_last[sel][head];
            out_user <= fifo_user[sel][head];
        end
    end

endmodule

// File: rtl/pattgen_top.sv
module pattgen_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  pattgen_pkg::ch_mask_t ch_enable,
    input  logic                  out_ready,
    output logic                  out_valid,
    output pattgen_pkg::pixel_t   out_data,
    output pattgen_pkg::ch_t      out_dest,
    output logic                  out_last,
    output logic                  out_user,
    output pattgen_pkg::frame_t   frame_count
);

    pattgen_pkg::ch_mask_t start;
    pattgen_pkg::ch_mask_t done;
    pattgen_pkg::ch_mask_t beat_valid;
    pattgen_pkg::ch_mask_t beat_last;
    pattgen_pkg::ch_mask_t beat_user;
    pattgen_pkg::ch_mask_t credit_ret;
    pattgen_pkg::pixel_t   beat_data [pattgen_pkg::NUM_CH];

    // the frame number seen by the generators is the one reported outside
    frame_scheduler i_sched (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .ch_enable (ch_enable),
        .done      (done),
        .start     (start),
        .frame     (frame_count)
    );

    for (genvar c = 0; c < pattgen_pkg::NUM_CH; c++) begin : g_ch
        pattern_gen i_gen (
            .clk        (clk),
            .rst        (rst),
            .start      (start[c]),
            .frame      (frame_count),
            .ch         (pattgen_pkg::ch_t'(c)),
            .credit_ret (credit_ret[c]),
            .beat_valid (beat_valid[c]),
            .beat_data  (beat_data[c]),
            .beat_last  (beat_last[c]),
            .beat_user  (beat_user[c]),
            .done       (done[c])
        );
    end

    stream_merger i_merge (
        .clk        (clk),
        .rst        (rst),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_last  (beat_last),
        .beat_user  (beat_user),
        .credit_ret (credit_ret),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_dest   (out_dest),
        .out_last   (out_last),
        .out_user   (out_user)
    );

endmodule

// File: bench/pattgen_props.sv
module pattgen_props (
    input logic                  clk,
    input logic                  rst,
    input logic                  out_valid,
    input logic                  out_ready,
    input pattgen_pkg::pixel_t   out_data,
    input pattgen_pkg::ch_t      out_dest,
    input logic                  out_last,
    input pattgen_pkg::ch_mask_t beat_valid,
    input pattgen_pkg::ptr_t     wr_ptr [pattgen_pkg::NUM_CH],
    input pattgen_pkg::ptr_t     rd_ptr [pattgen_pkg::NUM_CH]
);

    pattgen_pkg::ptr_t fill [pattgen_pkg::NUM_CH];    // beats held per channel buffer

    always_comb begin
        for (int c = 0; c < pattgen_pkg::NUM_CH; c++) begin
            fill[c] = wr_ptr[c] - rd_ptr[c];
        end
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data) && $stable(out_dest) && $stable(out_last))
        else $error("output beat changed while stalled");

    a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high during reset");

    for (genvar c = 0; c < pattgen_pkg::NUM_CH; c++) begin : g_ch
        a_depth: assert property (@(posedge clk) disable iff (rst)
            fill[c] <= pattgen_pkg::ptr_t'(pattgen_pkg::CREDITS))
            else $error("channel %0d buffers more beats than its depth", c);

        // a credit is only spent while a slot is free
        a_no_overrun: assert property (@(posedge clk) disable iff (rst)
            beat_valid[c] |-> fill[c] != pattgen_pkg::ptr_t'(pattgen_pkg::CREDITS))
            else $error("channel %0d wrote into a full buffer", c);
    end

endmodule

// File: bench/pattgen_tb.sv
module pattgen_tb;

    localparam int FRAME_BEATS  = pattgen_pkg::LINE_BEATS * pattgen_pkg::LINES_PER_FRAME;
    localparam int RESET_CYCLES = 8;
    localparam int TIMEOUT      = 8 * FRAME_BEATS * pattgen_pkg::NUM_CH * 4 + RESET_CYCLES;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  enable;
    pattgen_pkg::ch_mask_t ch_enable;
    logic                  out_ready;
    logic                  out_valid;
    pattgen_pkg::pixel_t   out_data;
    pattgen_pkg::ch_t      out_dest;
    logic                  out_last;
    logic                  out_user;
    pattgen_pkg::frame_t   frame_count;

    logic [31:0]           lfsr = 32'd85873;
    string                 test_name = "mask_sync";
    int                    cycle_count = 0;
    int                    mismatches = 0;
    int                    failures = 0;
    pattgen_pkg::frame_t   join_floor = '0;    // last frame on the output when the mask widened
    pattgen_pkg::frame_t   newest_frame = '0;

    // position of the next beat each channel should deliver
    logic                  started [pattgen_pkg::NUM_CH];
    logic                  seen [pattgen_pkg::NUM_CH];
    pattgen_pkg::frame_t   exp_frame [pattgen_pkg::NUM_CH];
    pattgen_pkg::line_t    exp_line [pattgen_pkg::NUM_CH];
    pattgen_pkg::beat_t    exp_beat [pattgen_pkg::NUM_CH];
    pattgen_pkg::frame_t   last_frame [pattgen_pkg::NUM_CH];
    int                    frames_out [pattgen_pkg::NUM_CH];
    logic                  prev_last;
    pattgen_pkg::ch_t      prev_dest;

    pattgen_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .ch_enable   (ch_enable),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_dest    (out_dest),
        .out_last    (out_last),
        .out_user    (out_user),
        .frame_count (frame_count)
    );

    bind stream_merger pattgen_props i_props (
        .clk        (clk),
        .rst        (rst),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_dest   (out_dest),
        .out_last   (out_last),
        .beat_valid (beat_valid),
        .wr_ptr     (wr_ptr),
        .rd_ptr     (rd_ptr)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? LFSR_TAPS : 32'd0);
    endfunction

    function automatic pattgen_pkg::pixel_t expected_pixel(input pattgen_pkg::frame_t frame,
                                                           input pattgen_pkg::ch_t    ch,
                                                           input pattgen_pkg::line_t  line,
                                                           input pattgen_pkg::beat_t  beat);
        pattgen_pkg::pixel_t p;
        p[15:10] = frame;
        p[9:8]   = ch;
        p[7:4]   = line;
        p[3:0]   = beat;
        return p;
    endfunction

    task automatic end_simulation(input logic timed_out);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (timed_out || mismatches != 0 || failures != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    endtask

    // channel 3 is never ahead of the others by more than a frame
    task automatic run_frames(input int frames, input logic random_ready);
        int target;
        target = frames_out[3] + frames;
        while (frames_out[3] < target) begin
            @(negedge clk);
            if (random_ready) begin
                out_ready = lfsr[0];
                lfsr      = lfsr_step(lfsr);
            end else begin
                out_ready = 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        pattgen_pkg::ch_t    c;
        pattgen_pkg::frame_t f;
        pattgen_pkg::frame_t gap;
        pattgen_pkg::pixel_t want;
        logic                want_last;
        logic                want_user;
        if (rst) begin
            for (int i = 0; i < pattgen_pkg::NUM_CH; i++) begin
                started[i]    = ch_enable[i];
                seen[i]       = 1'b0;
                exp_frame[i]  = '0;
                exp_line[i]   = '0;
                exp_beat[i]   = '0;
                last_frame[i] = '0;
                frames_out[i] = 0;
            end
            prev_last = 1'b1;
            prev_dest = '0;
        end else if (out_valid && out_ready) begin
            c = out_dest;
            f = out_data[15:10];
            if (!ch_enable[c]) begin
                failures++;
                $display("%s: beat from disabled channel %0d", test_name, c);
            end
            if (!started[c]) begin
                gap = f - join_floor;    // joining is only legal at the next frame boundary
                if (gap != pattgen_pkg::frame_t'(1)) begin
                    failures++;
                    $display("%s: channel %0d joined at frame %0d, not after frame %0d",
                             test_name, c, f, join_floor);
                end
                started[c]   = 1'b1;
                exp_frame[c] = join_floor + 1'b1;
            end
            for (int o = 0; o < pattgen_pkg::NUM_CH; o++) begin
                gap = f - last_frame[o];
                if (seen[o] && gap > 1 && gap != '1) begin
                    failures++;
                    $display("%s: channel %0d at frame %0d while channel %0d is at frame %0d",
                             test_name, c, f, o, last_frame[o]);
                end
            end
            want      = expected_pixel(exp_frame[c], c, exp_line[c], exp_beat[c]);
            want_last = exp_beat[c] == pattgen_pkg::beat_t'(pattgen_pkg::LINE_BEATS - 1);
            want_user = exp_line[c] == '0 && exp_beat[c] == '0;
            if (out_data !== want) begin
                mismatches++;
                $display("MISMATCH %s ch%0d data expected %h actual %h",
                         test_name, c, want, out_data);
            end
            if (out_last !== want_last) begin
                mismatches++;
                $display("MISMATCH %s ch%0d last expected %b actual %b",
                         test_name, c, want_last, out_last);
            end
            if (out_user !== want_user) begin
                mismatches++;
                $display("MISMATCH %s ch%0d user expected %b actual %b",
                         test_name, c, want_user, out_user);
            end
            // the first beat of a frame leaves long before that frame can end
            if (want_user && frame_count !== exp_frame[c]) begin
                mismatches++;
                $display("MISMATCH %s ch%0d frame_count expected %0d actual %0d",
                         test_name, c, exp_frame[c], frame_count);
            end
            if (!prev_last && out_dest != prev_dest) begin
                failures++;
                $display("%s: channel %0d cut into an open line of channel %0d",
                         test_name, c, prev_dest);
            end
            prev_last     = out_last;
            prev_dest     = out_dest;
            seen[c]       = 1'b1;
            last_frame[c] = f;
            newest_frame  = f;
            if (exp_beat[c] == pattgen_pkg::beat_t'(pattgen_pkg::LINE_BEATS - 1)) begin
                exp_beat[c] = '0;
                if (exp_line[c] == pattgen_pkg::line_t'(pattgen_pkg::LINES_PER_FRAME - 1)) begin
                    exp_line[c]  = '0;
                    exp_frame[c] = exp_frame[c] + 1'b1;
                    frames_out[c]++;
                end else begin
                    exp_line[c] = exp_line[c] + 1'b1;
                end
            end else begin
                exp_beat[c] = exp_beat[c] + 1'b1;
            end
        end
    end

    initial begin
        rst       = 1'b1;
        enable    = 1'b0;
        ch_enable = 4'b0101;
        out_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst    = 1'b0;
        enable = 1'b1;

        // widen the mask while channel 0 is halfway through its first frame
        while (exp_line[0] != pattgen_pkg::line_t'(2)) @(negedge clk);
        join_floor = newest_frame;
        ch_enable  = 4'b1111;
        run_frames(1, 1'b0);

        test_name = "pixel_values";
        run_frames(3, 1'b0);

        test_name = "back_pressure";
        run_frames(3, 1'b1);
        end_simulation(1'b0);
    end

    initial begin
        wait (cycle_count >= TIMEOUT);
        $display("timeout: the stream did not finish within %0d cycles", TIMEOUT);
        end_simulation(1'b1);
    end

endmodule

// File: vlog.f
rtl/pattgen_pkg.sv
rtl/frame_scheduler.sv
rtl/pattern_gen.sv
rtl/stream_merger.sv
rtl/pattgen_top.sv
bench/pattgen_props.sv
bench/pattgen_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := pattgen_tb
FILELIST := vlog.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -q '^Verification passed$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
